//--- bench/light_show_props.sv
module light_show_props (
	input logic                                    clk,
	input logic                                    rst_n,
	input logic [light_show_pkg::NUM_PATTERNS-1:0] go,
	input light_show_pkg::light_sel_t              sel,
	input light_show_pkg::lamp_word_t              led,
	input light_show_pkg::lamp_word_t              relay_n
);

	import light_show_pkg::*;

	relay_inverse: assert property (@(posedge clk) disable iff (!rst_n) relay_n == ~led)
		else $error("relay_n is not the inverse of led");

	one_player: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(go))
		else $error("more than one pattern player enabled");

	// mux output follows last cycle's sel
	dark_when_off: assert property (@(posedge clk) disable iff (!rst_n)
		($past(sel) == SEL_DARK) |-> (led == '0))
		else $error("led lit while the registered selection is dark");

endmodule

bind light_show_top light_show_props u_props (
	.clk    (clk),
	.rst_n  (rst_n),
	.go     (go),
	.sel    (sel),
	.led    (led),
	.relay_n(relay_n)
);

//--- bench/light_show_tb.sv
module light_show_tb;

	import light_show_pkg::*;

	localparam int STEP_CYCLES = 2;
	localparam int MAX_ROWS    = 16;
	localparam int AUTO_END    = 17 * 60 + 15; // pattern 4 takes over at 17:15

	typedef enum int {MODE_DARK, MODE_STEADY, MODE_PATTERN, MODE_SHOW, MODE_AUTO} mode_t;
	typedef enum int {LED_DARK, LED_LIT, LED_FRAME, LED_ALL_ON} led_cond_t;

	logic       clk;
	logic       rst_n;
	dip_code_t  dip;
	lamp_word_t led;
	lamp_word_t relay_n;

	string     row_name[MAX_ROWS];
	dip_code_t row_dip[MAX_ROWS];
	mode_t     row_mode[MAX_ROWS];
	int        row_pat[MAX_ROWS];   // pattern number or 0 when unused
	int        row_start[MAX_ROWS]; // minute of day before dip is applied
	int        row_watch[MAX_ROWS]; // cycles watched or the limit of a wait
	int        n_rows;
	int        checks;
	int        errors;
	int        timeouts;

	light_show_top #(
		.TICKS_PER_SECOND(2),
		.STEP_CYCLES     (STEP_CYCLES),
		.SETTLE_STEPS    (3),
		.START_HOUR      (16),
		.START_MINUTE    (59)
	) dut (
		.clk    (clk),
		.rst_n  (rst_n),
		.dip    (dip),
		.led    (led),
		.relay_n(relay_n)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// frame model and checks

	function automatic lamp_word_t frame_of(int k, int f);
		lamp_word_t w;
		int         j;
		w = '0;
		// first lit lamp and every (k+1)th lamp after it
		for (j = (k + 1 - f % (k + 1)) % (k + 1); j < NUM_LAMPS; j += k + 1)
			w[j] = 1'b1;
		return w;
	endfunction

	function automatic bit is_frame(int k, lamp_word_t w);
		for (int f = 0; f < FRAMES_PER_PASS; f++)
			if (frame_of(k, f) == w)
				return 1'b1;
		return 1'b0;
	endfunction

	function automatic int clock_minutes();
		return int'(dut.u_time.hour) * 60 + int'(dut.u_time.minute);
	endfunction

	task automatic check_word(string name, int k, lamp_word_t w);
		checks++;
		if (!is_frame(k, w)) begin
			errors++;
			$display("[ERROR] %s: expected a frame of pattern %0d, actual %b", name, k, w);
		end
	endtask

	task automatic check_value(string name, lamp_word_t exp, lamp_word_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic reach_time(string name, int target);
		int n;
		for (n = 0; n < 3000; n++) begin
			if (clock_minutes() >= target)
				break;
			@(negedge clk);
		end
		if (n == 3000) begin
			timeouts++;
			$display("%s: clock never reached minute %0d of the day", name, target);
		end
	endtask

	task automatic await_led(string name, led_cond_t cond, int k, int limit);
		int n;
		bit hit;
		hit = 1'b0;
		for (n = 0; n < limit && !hit; n++) begin
			@(negedge clk);
			case (cond)
				LED_DARK:  hit = (led == '0);
				LED_LIT:   hit = (led != '0);
				LED_FRAME: hit = is_frame(k, led);
				default:   hit = (led == '1);
			endcase
		end
		if (!hit) begin
			timeouts++;
			$display("%s: led did not reach %s within %0d cycles", name, cond.name(), limit);
		end
	endtask

	task automatic add_row(string name, dip_code_t code, mode_t mode, int pat, int start,
			int watch);
		row_name[n_rows]  = name;
		row_dip[n_rows]   = code;
		row_mode[n_rows]  = mode;
		row_pat[n_rows]   = pat;
		row_start[n_rows] = start;
		row_watch[n_rows] = watch;
		n_rows++;
	endtask

	////////////////////////////////////////////////////////////
	// one table row

	task automatic run_row(int i);
		int n;
		int len;
		int zeros;
		reach_time(row_name[i], row_start[i]);
		@(posedge clk);
		dip <= row_dip[i];
		case (row_mode[i])
			MODE_DARK: begin
				for (n = 0; n < row_watch[i]; n++) begin
					@(negedge clk);
					check_value(row_name[i], '0, led);
					check_value(row_name[i], '1, relay_n);
				end
			end
			MODE_STEADY: begin
				await_led(row_name[i], LED_ALL_ON, 0, 200);
				for (n = 0; n < row_watch[i]; n++) begin
					check_value(row_name[i], '1, led);
					check_value(row_name[i], '0, relay_n);
					@(negedge clk);
				end
			end
			MODE_PATTERN: begin
				await_led(row_name[i], LED_DARK, 0, 100); // old mode runs out
				await_led(row_name[i], LED_LIT, 0, 100);
				for (n = 0; n < row_watch[i]; n++) begin
					check_word(row_name[i], row_pat[i], led);
					@(negedge clk);
				end
			end
			MODE_SHOW: begin
				await_led(row_name[i], LED_DARK, 0, 100);
				for (n = 1; n <= int'(SHOW_LENGTH); n++) begin
					await_led(row_name[i], LED_LIT, 0, 100);
					// one pass ends at the dark gap
					for (len = 0; led != '0 && len < row_watch[i]; len++) begin
						check_word(row_name[i], n, led);
						@(negedge clk);
					end
					checks++;
					if (len < STEP_CYCLES * (FRAMES_PER_PASS - 1)) begin
						errors++;
						$display("[ERROR] %s: expected a pass of at least %0d cycles, actual %0d",
							row_name[i], STEP_CYCLES * (FRAMES_PER_PASS - 1), len);
					end
				end
			end
			default: begin
				await_led(row_name[i], LED_FRAME, row_pat[i], 400); // show may still finish
				zeros = 0;
				for (n = 0; n < row_watch[i] && clock_minutes() < AUTO_END; n++) begin
					if (led != '0) begin
						zeros = 0;
						check_word(row_name[i], row_pat[i], led);
					end else begin
						zeros++; // short gap between passes
						checks++;
						if (zeros > 3) begin
							errors++;
							$display("[ERROR] %s: expected at most 3 dark cycles, actual %0d",
								row_name[i], zeros);
						end
					end
					@(negedge clk);
				end
				if (n == row_watch[i]) begin
					timeouts++;
					$display("%s: clock never reached minute %0d of the day", row_name[i],
						AUTO_END);
				end
			end
		endcase
	endtask

	initial begin
		rst_n    = 1'b0;
		dip      = DIP_AUTO;
		n_rows   = 0;
		checks   = 0;
		errors   = 0;
		timeouts = 0;
		for (int c = 0; c < 8; c++)
			add_row($sformatf("dark_code%0d", c), dip_code_t'(c[2:0]), MODE_DARK, 0, 0, 10);
		add_row("steady_on", DIP_STEADY, MODE_STEADY, 0, 17 * 60, 24);
		add_row("manual_p1", DIP_P1, MODE_PATTERN, 1, 17 * 60, 40);
		add_row("manual_p2", DIP_P2, MODE_PATTERN, 2, 17 * 60, 40);
		add_row("manual_p3", DIP_P3, MODE_PATTERN, 3, 17 * 60, 40);
		add_row("manual_p4", DIP_P4, MODE_PATTERN, 4, 17 * 60, 40);
		add_row("manual_p5", DIP_P5, MODE_PATTERN, 5, 17 * 60, 40);
		add_row("show", DIP_SHOW, MODE_SHOW, 0, 17 * 60, 40);
		add_row("auto_p5", DIP_AUTO, MODE_AUTO, 5, 17 * 60 + 3, 2000);

		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		for (int i = 0; i < n_rows; i++)
			run_row(i);

		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

//--- filelist.f
source/light_show_pkg.sv
source/time_of_day.sv
source/show_sequencer.sv
source/pattern_player.sv
source/light_mux.sv
source/light_show_top.sv
bench/light_show_props.sv
bench/light_show_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the light show testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module light_show_tb -f filelist.f \
	-o light_show_sim \
	&& ./obj_dir/light_show_sim > sim.log 2>&1 \
	|| echo "** FAIL **" >> sim.log
grep -q "\*\* FAIL \*\*" sim.log && echo "simulation failed, see sim.log" && exit 1
grep -q "\*\* PASS \*\*" sim.log || { echo "no result in sim.log"; exit 1; }
echo "simulation passed"

//--- source/light_mux.sv
module light_mux (
	input  logic                                                 clk,
	input  logic                                                 rst_n,
	input  light_show_pkg::light_sel_t                           sel,
	input  light_show_pkg::lamp_word_t [light_show_pkg::NUM_PATTERNS-1:0] player_lamps,
	output light_show_pkg::lamp_word_t                           led,
	output light_show_pkg::lamp_word_t                           relay_n
);

	import light_show_pkg::*;

	light_sel_t sel_q;

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n)
			sel_q <= SEL_DARK;
		else
			sel_q <= sel;
	end

	always_comb begin
		led = '0;
		if (sel_q == SEL_STEADY) begin
			led = '1; // everything on
		end else begin
			for (int k = 0; k < NUM_PATTERNS; k++) begin
				if (3'(sel_q) == 3'(k + 1))
					led = player_lamps[k];
			end
		end
	end

	assign relay_n = ~led; // relays are active low

endmodule

//--- source/light_show_pkg.sv
package light_show_pkg;

	////////////////////////////////////////////////////////////
	// sizes

	localparam int NUM_LAMPS       = 8;
	localparam int NUM_PATTERNS    = 5;
	localparam int FRAMES_PER_PASS = 8;

	////////////////////////////////////////////////////////////
	// schedule

	localparam logic [4:0] HOUR_ON  = 5'd17; // 5pm
	localparam logic [4:0] HOUR_OFF = 5'd24; // midnight

	localparam logic [5:0] SHOW_END_MIN      = 6'd3;
	localparam logic [5:0] PATTERN_START_MIN = 6'd15;
	localparam logic [5:0] PATTERN_END_MIN   = 6'd50;

	localparam logic [1:0] SHOW_LENGTH = 2'd3; // patterns 1..3 once each

	typedef logic [NUM_LAMPS-1:0] lamp_word_t;

	typedef enum logic [2:0] {
		DIP_AUTO, DIP_P1, DIP_P2, DIP_P3, DIP_P4, DIP_P5, DIP_SHOW, DIP_STEADY
	} dip_code_t;

	typedef enum logic [2:0] {
		SEL_DARK, SEL_P1, SEL_P2, SEL_P3, SEL_P4, SEL_P5, SEL_STEADY
	} light_sel_t;

	typedef enum logic [2:0] {
		SEQ_SETTLE, SEQ_OFF, SEQ_DECIDE, SEQ_PLAY, SEQ_SHOW, SEQ_STEADY
	} seq_state_t;

endpackage

//--- source/light_show_top.sv
module light_show_top #(
	parameter int TICKS_PER_SECOND = 50_000_000,
	parameter int STEP_CYCLES      = 5_000_000,
	parameter int SETTLE_STEPS     = 20,
	parameter int START_HOUR       = 17,
	parameter int START_MINUTE     = 10
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  light_show_pkg::dip_code_t  dip,
	output light_show_pkg::lamp_word_t led,
	output light_show_pkg::lamp_word_t relay_n
);

	import light_show_pkg::*;

	logic [4:0]                    hour;
	logic [5:0]                    minute;
	logic                          step_tick;
	logic [NUM_PATTERNS-1:0]       go;
	logic [NUM_PATTERNS-1:0]       done;
	light_sel_t                    sel;
	lamp_word_t [NUM_PATTERNS-1:0] player_lamps;

	time_of_day #(
		.TICKS_PER_SECOND(TICKS_PER_SECOND),
		.STEP_CYCLES     (STEP_CYCLES),
		.START_HOUR      (START_HOUR),
		.START_MINUTE    (START_MINUTE)
	) u_time (
		.clk      (clk),
		.rst_n    (rst_n),
		.hour     (hour),
		.minute   (minute),
		.step_tick(step_tick)
	);

	show_sequencer #(
		.SETTLE_STEPS(SETTLE_STEPS)
	) u_seq (
		.clk      (clk),
		.rst_n    (rst_n),
		.dip      (dip),
		.hour     (hour),
		.minute   (minute),
		.step_tick(step_tick),
		.done     (done),
		.go       (go),
		.sel      (sel)
	);

	////////////////////////////////////////////////////////////
	// pattern engines 1..5

	for (genvar k = 0; k < NUM_PATTERNS; k++) begin : g_player
		pattern_player #(
			.PATTERN_INDEX(k + 1)
		) u_player (
			.clk      (clk),
			.rst_n    (rst_n),
			.go       (go[k]),
			.step_tick(step_tick),
			.lamps    (player_lamps[k]),
			.done     (done[k])
		);
	end

	light_mux u_mux (
		.clk         (clk),
		.rst_n       (rst_n),
		.sel         (sel),
		.player_lamps(player_lamps),
		.led         (led),
		.relay_n     (relay_n)
	);

endmodule

//--- source/pattern_player.sv
module pattern_player #(
	parameter int PATTERN_INDEX = 1
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       go,
	input  logic                       step_tick,
	output light_show_pkg::lamp_word_t lamps,
	output logic                       done
);

	import light_show_pkg::*;

	localparam int FW     = $clog2(FRAMES_PER_PASS);
	localparam int PERIOD = PATTERN_INDEX + 1; // lamp spacing
	localparam logic [FW-1:0] LAST_FRAME = FW'(FRAMES_PER_PASS - 1);

	logic [FW-1:0] frame;

	// one step tick wide at the end of a pass
	assign done = go && step_tick && (frame == LAST_FRAME);

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n)
			frame <= '0;
		else if (!go)
			frame <= '0; // parked at the first frame
		else if (step_tick)
			frame <= (frame == LAST_FRAME) ? '0 : frame + 1'b1;
	end

	////////////////////////////////////////////////////////////
	// frame to lamp word

	always_comb begin
		for (int j = 0; j < NUM_LAMPS; j++) begin
			// lit when j + frame is a multiple of PERIOD
			lamps[j] = go && (((j + int'(frame)) % PERIOD) == 0);
		end
	end

endmodule

//--- source/show_sequencer.sv
module show_sequencer #(
	parameter int SETTLE_STEPS = 20
) (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  light_show_pkg::dip_code_t              dip,
	input  logic [4:0]                             hour,
	input  logic [5:0]                             minute,
	input  logic                                   step_tick,
	input  logic [light_show_pkg::NUM_PATTERNS-1:0] done,
	output logic [light_show_pkg::NUM_PATTERNS-1:0] go,
	output light_show_pkg::light_sel_t             sel
);

	import light_show_pkg::*;

	localparam int SW = $clog2(SETTLE_STEPS + 1);
	localparam logic [SW-1:0] SETTLE_LAST = SW'(SETTLE_STEPS);

	seq_state_t    state;
	logic [SW-1:0] settle_cnt;
	logic [1:0]    show_idx;   // next show pattern counted from 0
	light_sel_t    play_sel;   // pattern held in SEQ_PLAY
	logic          show_play;  // play_sel came from the show
	logic          in_window;
	logic          settled;
	logic          play_done;
	logic          dip_names_play;
	logic [2:0]    play_num;

	assign in_window      = (hour >= HOUR_ON) && (hour < HOUR_OFF);
	assign settled        = (settle_cnt == SETTLE_LAST);
	assign play_num       = 3'(play_sel) - 3'd1;
	assign play_done      = |(done & go);
	assign dip_names_play = (3'(dip) == 3'(play_sel));

	////////////////////////////////////////////////////////////
	// outputs follow the state

	always_comb begin
		go  = '0;
		sel = SEL_DARK;
		if (state == SEQ_PLAY) begin
			go[play_num] = 1'b1; // one hot
			sel          = play_sel;
		end else if (state == SEQ_STEADY) begin
			sel = SEL_STEADY;
		end
	end

	// settle delay counts step ticks only while settling
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n)
			settle_cnt <= '0;
		else if (state != SEQ_SETTLE)
			settle_cnt <= '0;
		else if (step_tick && !settled)
			settle_cnt <= settle_cnt + 1'b1;
	end

	////////////////////////////////////////////////////////////
	// state machine

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			state     <= SEQ_SETTLE;
			show_idx  <= '0;
			play_sel  <= SEL_P1;
			show_play <= 1'b0;
		end else if (!in_window) begin
			state    <= SEQ_OFF; // dark outside the evening
			show_idx <= '0;
		end else begin
			case (state)
				SEQ_OFF: begin
					if (hour == HOUR_ON)
						state <= SEQ_SETTLE;
				end
				SEQ_SETTLE: begin
					if (settled) begin
						case (dip)
							DIP_STEADY: state <= SEQ_STEADY;
							DIP_SHOW:   state <= SEQ_SHOW;
							DIP_AUTO:   state <= SEQ_DECIDE;
							default: begin
								play_sel  <= light_sel_t'(dip); // codes line up
								show_play <= 1'b0;
								state     <= SEQ_PLAY;
							end
						endcase
					end
				end
				SEQ_DECIDE: begin
					show_play <= 1'b0;
					if (show_idx != 2'd0) begin
						state <= SEQ_SHOW; // finish a running show first
					end else if (minute >= PATTERN_END_MIN) begin
						play_sel <= SEL_P5;
						state    <= SEQ_PLAY;
					end else if (minute >= PATTERN_START_MIN) begin
						play_sel <= SEL_P4;
						state    <= SEQ_PLAY;
					end else if (minute >= SHOW_END_MIN) begin
						play_sel <= SEL_P5;
						state    <= SEQ_PLAY;
					end else begin
						state <= SEQ_SHOW; // top of the hour
					end
				end
				SEQ_PLAY: begin
					// a pass always completes before leaving
					if (play_done && !dip_names_play) begin
						if ((dip == DIP_AUTO || dip == DIP_SHOW) && show_play) begin
							show_idx <= show_idx + 2'd1;
							state    <= SEQ_DECIDE;
						end else begin
							show_idx <= '0;
							state    <= (dip == DIP_AUTO) ? SEQ_DECIDE : SEQ_SETTLE;
						end
					end
				end
				SEQ_SHOW: begin
					if (show_idx == SHOW_LENGTH) begin
						show_idx <= '0;
						state    <= SEQ_SETTLE;
					end else begin
						play_sel  <= light_sel_t'(3'(show_idx) + 3'd1);
						show_play <= 1'b1;
						state     <= SEQ_PLAY;
					end
				end
				SEQ_STEADY: begin
					if (dip != DIP_STEADY)
						state <= SEQ_SETTLE;
				end
				default: state <= SEQ_SETTLE;
			endcase
		end
	end

endmodule

//--- source/time_of_day.sv
module time_of_day #(
	parameter int TICKS_PER_SECOND = 50_000_000,
	parameter int STEP_CYCLES      = 5_000_000,
	parameter int START_HOUR       = 17,
	parameter int START_MINUTE     = 10
) (
	input  logic       clk,
	input  logic       rst_n,
	output logic [4:0] hour,
	output logic [5:0] minute,
	output logic       step_tick
);

	localparam int TW = $clog2(TICKS_PER_SECOND + 1);
	localparam int PW = $clog2(STEP_CYCLES + 1);
	localparam logic [TW-1:0] TICK_LAST = TW'(TICKS_PER_SECOND - 1);
	localparam logic [PW-1:0] STEP_LAST = PW'(STEP_CYCLES - 1);

	logic [TW-1:0] tick_cnt;
	logic [PW-1:0] step_cnt;
	logic [5:0]    second;
	logic          sec_tick;
	logic          min_tick;
	logic          hour_tick;

	assign sec_tick  = (tick_cnt == TICK_LAST);
	assign min_tick  = sec_tick && (second == 6'd59);
	assign hour_tick = min_tick && (minute == 6'd59);
	assign step_tick = (step_cnt == STEP_LAST); // one cycle wide

	////////////////////////////////////////////////////////////
	// wall clock

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			tick_cnt <= '0;
			second   <= '0;
			minute   <= 6'(START_MINUTE);
			hour     <= 5'(START_HOUR);
		end else begin
			tick_cnt <= sec_tick ? '0 : tick_cnt + 1'b1;
			if (sec_tick)
				second <= (second == 6'd59) ? 6'd0 : second + 6'd1;
			if (min_tick)
				minute <= (minute == 6'd59) ? 6'd0 : minute + 6'd1;
			if (hour_tick)
				hour <= (hour == 5'd23) ? 5'd0 : hour + 5'd1; // wraps at midnight
		end
	end

	// free running frame step prescaler
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n)
			step_cnt <= '0;
		else
			step_cnt <= step_tick ? '0 : step_cnt + 1'b1;
	end

endmodule
